/* logic/lcd_defines.svh */
// shared widths, reset phase length and control-word bit positions for the i80 LCD controller
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// ============================================================
// bus widths
// ============================================================

`define LCD_DB_WIDTH      16   // panel data bus
`define LCD_HOST_WIDTH    32   // host register port data

// ============================================================
// control word at address 2
// ============================================================

`define LCD_PHASE_WIDTH   8    // phase length field, low bits
`define LCD_PHASE_RESET   8'd8 // phase length after reset
`define LCD_CTRL_RST_BIT  31   // software panel reset, top bit

// Bits between the reset flag and the phase field are reserved.
// They read back as zero and writes to them are dropped.
`define LCD_CTRL_PAD_WIDTH (`LCD_CTRL_RST_BIT - `LCD_PHASE_WIDTH)

`endif

/* logic/lcd_host_pkg.sv */
// host-side types for the i80 LCD controller, imported by the FSM, data path and testbench
`include "lcd_defines.svh"

package lcd_host_pkg;

	// register map of the host port
	typedef enum logic [1:0] {
		ADDR_INDEX = 2'd0, // panel index/status, rs low
		ADDR_DATA  = 2'd1, // panel control/data, rs high
		ADDR_CTRL  = 2'd2, // local control word
		ADDR_NONE  = 2'd3  // unmapped, reads zero
	} lcd_addr_e;

	// panel access view of the host word
	typedef struct packed {
		logic [`LCD_HOST_WIDTH-`LCD_DB_WIDTH-1:0] unused; // always zero on reads
		logic [`LCD_DB_WIDTH-1:0]                 word;   // value on the panel bus
	} lcd_data_view_t;

	// control register view of the host word
	typedef struct packed {
		logic                           panel_rst; // holds the panel in reset
		logic [`LCD_CTRL_PAD_WIDTH-1:0] unused;
		logic [`LCD_PHASE_WIDTH-1:0]    phase_len; // clocks per bus phase, minus one
	} lcd_ctrl_view_t;

	// The same 32-bit word means different things depending on the address.
	typedef union packed {
		lcd_data_view_t data;
		lcd_ctrl_view_t ctrl;
	} lcd_host_word_u;

endpackage

/* logic/lcd_panel_pkg.sv */
// panel-side types for the i80 LCD controller, shared by the bus FSM, data path and top level
package lcd_panel_pkg;

	// ============================================================
	// bus cycle sequencing
	// ============================================================

	typedef enum logic [2:0] {
		IDLE       = 3'd0, // waiting for a host request
		SETUP      = 3'd1, // rs valid, strobes still high
		STROBE     = 3'd2, // cs and rd or wr low
		HOLD_READY = 3'd3  // ready high until request drops
	} lcd_cycle_state_e;

	// ============================================================
	// read data source
	// ============================================================

	typedef enum logic [1:0] {
		RSEL_PANEL = 2'd0, // word captured from the panel bus
		RSEL_CTRL  = 2'd1, // local control register
		RSEL_ZERO  = 2'd2  // unmapped address
	} lcd_rsel_e;

endpackage

/* logic/lcd_phase_timer.sv */
// down-counter that times one i80 bus phase, started by the bus FSM and pulsing when it runs out
`timescale 1ns/1ns
`include "lcd_defines.svh"

module lcd_phase_timer (
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  logic                        i_start,  // loads i_length even mid-count
	input  logic [`LCD_PHASE_WIDTH-1:0] i_length,
	output logic                        o_expired
);

	logic [`LCD_PHASE_WIDTH-1:0] count_q;
	logic                        active_q;

	// A phase of length N spans N+1 cycles, the last one with the count at zero.
	assign o_expired = active_q && (count_q == '0);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count_q  <= '0;
			active_q <= 1'b0;
		end else if (i_start) begin
			count_q  <= i_length;
			active_q <= 1'b1;
		end else if (active_q) begin
			if (count_q == '0) begin
				active_q <= 1'b0; // expired, wait for next start
			end else begin
				count_q <= count_q - 1'b1;
			end
		end
	end

endmodule

/* logic/lcd_bus_fsm.sv */
// state machine turning one host register access into an i80 setup and strobe cycle
`timescale 1ns/1ns

module lcd_bus_fsm (
	input  logic                     i_clock,
	input  logic                     i_rst_n,
	input  logic                     i_request,
	input  logic                     i_rw,         // 1 = write
	input  lcd_host_pkg::lcd_addr_e  i_address,
	input  logic                     i_expired,
	output logic                     o_timer_start,
	output logic                     o_latch_wdata,
	output logic                     o_capture,
	output logic                     o_ctrl_write,
	output logic                     o_drive_bus,
	output lcd_panel_pkg::lcd_rsel_e o_rsel,
	output logic                     o_ready,
	output logic                     o_lcd_cs_n,
	output logic                     o_lcd_rd_n,
	output logic                     o_lcd_wr_n,
	output logic                     o_lcd_rs
);

	import lcd_host_pkg::*;
	import lcd_panel_pkg::*;

	lcd_cycle_state_e state_q;
	logic             rw_q;         // direction of the access in flight
	logic             accept;
	logic             panel_access;

	// ============================================================
	// single-cycle pulses
	// ============================================================

	assign accept       = (state_q == IDLE) && i_request;
	assign panel_access = (i_address == ADDR_INDEX) || (i_address == ADDR_DATA);

	// timer runs once for setup and once for the strobe
	assign o_timer_start = (accept && panel_access) || ((state_q == SETUP) && i_expired);
	assign o_latch_wdata = accept;
	assign o_capture     = (state_q == STROBE) && i_expired && !rw_q; // bus still held by panel
	assign o_ctrl_write  = accept && i_rw && (i_address == ADDR_CTRL);

	// ============================================================
	// cycle sequencing and panel control lines
	// ============================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q     <= IDLE;
			rw_q        <= 1'b0;
			o_rsel      <= RSEL_ZERO;
			o_drive_bus <= 1'b0;
			o_ready     <= 1'b0;
			o_lcd_cs_n  <= 1'b1;
			o_lcd_rd_n  <= 1'b1;
			o_lcd_wr_n  <= 1'b1;
			o_lcd_rs    <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (i_request) begin
						rw_q <= i_rw;
						if (panel_access) begin
							o_lcd_rs    <= (i_address == ADDR_DATA);
							o_rsel      <= RSEL_PANEL;
							o_drive_bus <= i_rw; // write data out from acceptance
							state_q     <= SETUP;
						end else begin
							// local register, answered without touching the panel
							o_rsel  <= (i_address == ADDR_CTRL) ? RSEL_CTRL : RSEL_ZERO;
							o_ready <= 1'b1;
							state_q <= HOLD_READY;
						end
					end
				end

				SETUP: begin
					if (i_expired) begin
						o_lcd_cs_n <= 1'b0;
						o_lcd_rd_n <= rw_q;  // low for reads
						o_lcd_wr_n <= !rw_q; // low for writes
						state_q    <= STROBE;
					end
				end

				STROBE: begin
					if (i_expired) begin
						o_lcd_cs_n  <= 1'b1;
						o_lcd_rd_n  <= 1'b1;
						o_lcd_wr_n  <= 1'b1;
						o_drive_bus <= 1'b0;
						o_ready     <= 1'b1; // same edge as the read capture
						state_q     <= HOLD_READY;
					end
				end

				HOLD_READY: begin
					if (!i_request) begin
						o_ready <= 1'b0;
						state_q <= IDLE;
					end
				end

				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

endmodule

/* logic/lcd_data_path.sv */
// data path of the i80 LCD controller with write latch, bus tristate, read capture and control word
`timescale 1ns/1ns
`include "lcd_defines.svh"

module lcd_data_path (
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  logic [`LCD_HOST_WIDTH-1:0]  i_wdata,
	input  logic                        i_latch_wdata,
	input  logic                        i_capture,
	input  logic                        i_ctrl_write,
	input  logic                        i_drive_bus,
	input  lcd_panel_pkg::lcd_rsel_e    i_rsel,
	output logic [`LCD_HOST_WIDTH-1:0]  o_rdata,
	output logic [`LCD_PHASE_WIDTH-1:0] o_phase_length,
	output logic                        o_panel_reset_n,
	inout  wire  [`LCD_DB_WIDTH-1:0]    io_lcd_db
);

	import lcd_host_pkg::*;
	import lcd_panel_pkg::*;

	lcd_host_word_u              wr_word;
	lcd_host_word_u              rd_word;
	logic [`LCD_DB_WIDTH-1:0]    wdata_q;    // word put on the bus
	logic [`LCD_DB_WIDTH-1:0]    capture_q;  // word read from the panel
	logic [`LCD_PHASE_WIDTH-1:0] phase_q;
	logic                        ctrl_rst_q;
	logic                        panel_rst_n_q;

	assign wr_word   = i_wdata;
	assign io_lcd_db = i_drive_bus ? wdata_q : {`LCD_DB_WIDTH{1'bz}};

	always_ff @(posedge i_clock) begin
		if (i_latch_wdata) begin
			wdata_q <= wr_word.data.word;
		end
		if (i_capture) begin
			capture_q <= io_lcd_db;
		end
	end

	// ============================================================
	// control register at address 2
	// ============================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase_q       <= `LCD_PHASE_RESET;
			ctrl_rst_q    <= 1'b0;
			panel_rst_n_q <= 1'b0; // panel held in reset with the controller
		end else begin
			if (i_ctrl_write) begin
				phase_q    <= wr_word.ctrl.phase_len;
				ctrl_rst_q <= wr_word.ctrl.panel_rst;
			end
			panel_rst_n_q <= !ctrl_rst_q;
		end
	end

	// read word by source, unused bits zero
	always_comb begin
		rd_word = '0;
		case (i_rsel)
			RSEL_PANEL: rd_word.data.word = capture_q;
			RSEL_CTRL: begin
				rd_word.ctrl.panel_rst = ctrl_rst_q;
				rd_word.ctrl.phase_len = phase_q;
			end
			default: rd_word = '0;
		endcase
	end

	assign o_rdata         = rd_word;
	assign o_phase_length  = phase_q;
	assign o_panel_reset_n = panel_rst_n_q;

endmodule

/* logic/lcd_i80_ctrl.sv */
// top level of the i80 LCD controller, connecting the host register port to the panel pins
`timescale 1ns/1ns
`include "lcd_defines.svh"

module lcd_i80_ctrl (
	input  logic                       i_clock,
	input  logic                       i_rst_n,
	input  logic                       i_request,
	input  logic                       i_rw,
	input  logic [1:0]                 i_address,
	input  logic [`LCD_HOST_WIDTH-1:0] i_wdata,
	output logic [`LCD_HOST_WIDTH-1:0] o_rdata,
	output logic                       o_ready,
	output logic                       o_lcd_rst_n,
	output logic                       o_lcd_cs_n,
	output logic                       o_lcd_rd_n,
	output logic                       o_lcd_wr_n,
	output logic                       o_lcd_rs,
	inout  wire  [`LCD_DB_WIDTH-1:0]   io_lcd_db
);

	import lcd_host_pkg::*;
	import lcd_panel_pkg::*;

	logic                        timer_start;
	logic                        expired;
	logic                        latch_wdata;
	logic                        capture;
	logic                        ctrl_write;
	logic                        drive_bus;
	lcd_rsel_e                   rsel;
	logic [`LCD_PHASE_WIDTH-1:0] phase_length; // from control register to timer

	lcd_bus_fsm u_bus_fsm (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_request     (i_request),
		.i_rw          (i_rw),
		.i_address     (lcd_addr_e'(i_address)),
		.i_expired     (expired),
		.o_timer_start (timer_start),
		.o_latch_wdata (latch_wdata),
		.o_capture     (capture),
		.o_ctrl_write  (ctrl_write),
		.o_drive_bus   (drive_bus),
		.o_rsel        (rsel),
		.o_ready       (o_ready),
		.o_lcd_cs_n    (o_lcd_cs_n),
		.o_lcd_rd_n    (o_lcd_rd_n),
		.o_lcd_wr_n    (o_lcd_wr_n),
		.o_lcd_rs      (o_lcd_rs)
	);

	lcd_phase_timer u_phase_timer (
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_start   (timer_start),
		.i_length  (phase_length),
		.o_expired (expired)
	);

	lcd_data_path u_data_path (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_wdata         (i_wdata),
		.i_latch_wdata   (latch_wdata),
		.i_capture       (capture),
		.i_ctrl_write    (ctrl_write),
		.i_drive_bus     (drive_bus),
		.i_rsel          (rsel),
		.o_rdata         (o_rdata),
		.o_phase_length  (phase_length),
		.o_panel_reset_n (o_lcd_rst_n),
		.io_lcd_db       (io_lcd_db)
	);

endmodule

/* test/lcd_panel_model.sv */
// behavioral i80 LCD panel for the testbench, holding an index register and 16 data registers
`timescale 1ns/1ns
`include "lcd_defines.svh"

module lcd_panel_model (
	input  logic                     i_clock,
	input  logic                     i_rst_n,        // system reset, clears the register file
	input  logic                     i_cs_n,
	input  logic                     i_rd_n,
	input  logic                     i_wr_n,
	input  logic                     i_rs,           // 0 = index, 1 = data
	inout  wire  [`LCD_DB_WIDTH-1:0] io_db,
	output logic [7:0]               o_last_strobe   // cycles cs was low in the last access
);

	logic [`LCD_DB_WIDTH-1:0] index_q;
	logic [`LCD_DB_WIDTH-1:0] data_q [0:15];
	logic [7:0]               low_count;

	// panel answers only while the read strobe is low
	assign io_db = (!i_cs_n && !i_rd_n) ? (i_rs ? data_q[index_q[3:0]] : index_q)
	                                    : {`LCD_DB_WIDTH{1'bz}};

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			index_q       <= '0;
			data_q        <= '{default: '0};
			low_count     <= '0;
			o_last_strobe <= '0;
		end else begin
			// every strobe cycle stores the bus, the one before the rising edge wins
			if (!i_cs_n && !i_wr_n) begin
				if (i_rs) begin
					data_q[index_q[3:0]] <= io_db;
				end else begin
					index_q <= io_db;
				end
			end
			if (!i_cs_n) begin
				low_count <= low_count + 1'b1;
			end else if (low_count != '0) begin
				o_last_strobe <= low_count; // strobe just ended
				low_count     <= '0;
			end
		end
	end

endmodule

/* test/tb_lcd_i80_ctrl.sv */
// testbench for the i80 LCD controller, runs host accesses against a panel model and checks them
`timescale 1ns/1ns
`include "lcd_defines.svh"

module tb_lcd_i80_ctrl;

	import lcd_host_pkg::*;

	localparam int CLOCK_PERIOD   = 8;
	localparam int ACCESS_TIMEOUT = 600; // longest access at phase 255 is 513 cycles

	logic                       clock;
	logic                       rst_n;
	logic                       request;
	logic                       rw;
	lcd_addr_e                  address;
	logic [`LCD_HOST_WIDTH-1:0] wdata;
	logic [`LCD_HOST_WIDTH-1:0] rdata;
	logic                       ready;
	logic                       lcd_rst_n;
	logic                       cs_n;
	logic                       rd_n;
	logic                       wr_n;
	logic                       rs;
	wire  [`LCD_DB_WIDTH-1:0]   lcd_db;
	logic [7:0]                 last_strobe;

	// mirror of the panel registers and the control word
	logic [`LCD_DB_WIDTH-1:0] mir_index;
	logic [`LCD_DB_WIDTH-1:0] mir_data [0:15];
	lcd_host_word_u           mir_ctrl;

	string     test_name;
	integer    seed;
	int        errors;
	int        cmp_errors;
	int        checks;
	int        reads_issued;
	int        reads_compared;
	int        cs_falls;
	time       accept_time;
	time       cs_fall_time;
	logic      cmp_armed;
	lcd_addr_e cmp_addr;
	logic      ready_q;

	lcd_i80_ctrl u_dut (
		.i_clock     (clock),
		.i_rst_n     (rst_n),
		.i_request   (request),
		.i_rw        (rw),
		.i_address   (address),
		.i_wdata     (wdata),
		.o_rdata     (rdata),
		.o_ready     (ready),
		.o_lcd_rst_n (lcd_rst_n),
		.o_lcd_cs_n  (cs_n),
		.o_lcd_rd_n  (rd_n),
		.o_lcd_wr_n  (wr_n),
		.o_lcd_rs    (rs),
		.io_lcd_db   (lcd_db)
	);

	lcd_panel_model u_panel (
		.i_clock       (clock),
		.i_rst_n       (rst_n),
		.i_cs_n        (cs_n),
		.i_rd_n        (rd_n),
		.i_wr_n        (wr_n),
		.i_rs          (rs),
		.io_db         (lcd_db),
		.o_last_strobe (last_strobe)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(negedge cs_n) begin
		cs_fall_time = $time;
		cs_falls++;
	end

	// ============================================================
	// expected read data and comparison
	// ============================================================

	function automatic logic [31:0] lcd_expect(input lcd_addr_e addr);
		lcd_host_word_u word;
		word = '0;
		case (addr)
			ADDR_INDEX: word.data.word = mir_index;
			ADDR_DATA:  word.data.word = mir_data[mir_index[3:0]];
			ADDR_CTRL:  word = mir_ctrl;
			default:    word = '0; // unmapped reads zero
		endcase
		return word;
	endfunction

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= ready;
			if (ready && !ready_q && cmp_armed) begin
				reads_compared++;
				if (rdata !== lcd_expect(cmp_addr)) begin
					$display("CHECK FAILED [%s] read addr %0d: expected 0x%08h, actual 0x%08h",
						test_name, cmp_addr, lcd_expect(cmp_addr), rdata);
					cmp_errors++;
				end
			end
		end
	end

	// ============================================================
	// host tasks
	// ============================================================

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("CHECK FAILED [%s] %s: expected 0x%08h, actual 0x%08h",
				test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic host_access(input logic is_write, input lcd_addr_e addr,
			input logic [31:0] data, input int hold);
		int waited;
		int latency;
		int i;
		latency = 1; // local registers answer on the next edge
		if ((addr == ADDR_INDEX) || (addr == ADDR_DATA)) begin
			latency = 2 * int'(mir_ctrl.ctrl.phase_len) + 3;
		end
		cmp_addr  = addr;
		cmp_armed = !is_write;
		rw        = is_write;
		address   = addr;
		wdata     = data;
		request   = 1'b1;
		@(posedge clock);
		accept_time = $time; // controller idle, so this edge accepts
		#1;
		waited = 1;
		while (!ready && waited < ACCESS_TIMEOUT) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!ready) begin
			$display("[%s] no ready from the DUT within %0d cycles", test_name, ACCESS_TIMEOUT);
			errors++;
		end else begin
			check_value("access latency", 32'(latency), 32'(waited));
		end
		for (i = 0; i < hold; i++) begin
			@(posedge clock);
			#1;
			check_value("ready held", 32'd1, 32'(ready));
		end
		request = 1'b0;
		@(posedge clock);
		#1;
		check_value("ready drop", 32'd0, 32'(ready));
		cmp_armed = 1'b0;
		if (!is_write) begin
			reads_issued++;
		end
	endtask

	task automatic write_reg(input lcd_addr_e addr, input logic [31:0] value);
		lcd_host_word_u word;
		host_access(1'b1, addr, value, 0);
		word = value;
		case (addr)
			ADDR_INDEX: mir_index = word.data.word;
			ADDR_DATA:  mir_data[mir_index[3:0]] = word.data.word;
			ADDR_CTRL: begin
				mir_ctrl                = '0; // reserved bits dropped
				mir_ctrl.ctrl.panel_rst = word.ctrl.panel_rst;
				mir_ctrl.ctrl.phase_len = word.ctrl.phase_len;
			end
			default: ;
		endcase
	endtask

	task automatic read_reg(input lcd_addr_e addr);
		host_access(1'b0, addr, 32'd0, 0);
	endtask

	task automatic wait_panel_reset(input logic level);
		int waited;
		waited = 0;
		while (lcd_rst_n !== level && waited < 10) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (lcd_rst_n !== level) begin
			$display("[%s] panel reset pin did not reach %0d within 10 cycles", test_name, level);
			errors++;
		end
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		int             i;
		int             falls;
		logic [7:0]     phase;
		lcd_host_word_u word;
		seed           = 32'h6ae6;
		errors         = 0;
		cmp_errors     = 0;
		checks         = 0;
		reads_issued   = 0;
		reads_compared = 0;
		cs_falls       = 0;
		accept_time    = 0;
		cs_fall_time   = 0;
		cmp_armed      = 1'b0;
		cmp_addr       = ADDR_NONE;
		rst_n          = 1'b0;
		request        = 1'b0;
		rw             = 1'b0;
		address        = ADDR_INDEX;
		wdata          = '0;
		mir_index      = '0;
		mir_data       = '{default: '0};
		mir_ctrl       = '0;
		mir_ctrl.ctrl.phase_len = `LCD_PHASE_RESET;

		test_name = "reset";
		repeat (5) @(posedge clock);
		#1;
		check_value("ready", 32'd0, 32'(ready));
		check_value("cs_n", 32'd1, 32'(cs_n));
		check_value("rd_n", 32'd1, 32'(rd_n));
		check_value("wr_n", 32'd1, 32'(wr_n));
		check_value("panel reset", 32'd0, 32'(lcd_rst_n));
		if (lcd_db !== {`LCD_DB_WIDTH{1'bz}}) begin
			$display("CHECK FAILED [%s] bus: expected zzzz, actual %h", test_name, lcd_db);
			errors++;
		end
		rst_n = 1'b1;
		wait_panel_reset(1'b1);
		read_reg(ADDR_CTRL); // phase length after reset

		test_name = "panel registers";
		for (i = 0; i < 8; i++) begin
			write_reg(ADDR_INDEX, $random(seed));
			read_reg(ADDR_INDEX);
			write_reg(ADDR_DATA, $random(seed));
			read_reg(ADDR_DATA);
		end

		test_name = "phase length";
		for (i = 0; i < 3; i++) begin
			phase = (i == 0) ? 8'd3 : ((i == 1) ? 8'd0 : 8'd12);
			word  = $random(seed); // reserved bits random
			word.ctrl.panel_rst = 1'b0;
			word.ctrl.phase_len = phase;
			write_reg(ADDR_CTRL, word);
			read_reg(ADDR_CTRL);
			write_reg(ADDR_INDEX, $random(seed));
			check_value("setup width", 32'(phase) + 1,
				32'((cs_fall_time - accept_time) / CLOCK_PERIOD));
			check_value("write strobe width", 32'(phase) + 1, 32'(last_strobe));
			read_reg(ADDR_INDEX);
			check_value("read strobe width", 32'(phase) + 1, 32'(last_strobe));
		end
		word = '0;
		word.ctrl.phase_len = `LCD_PHASE_RESET;
		write_reg(ADDR_CTRL, word);

		test_name = "panel reset bit";
		word.ctrl.panel_rst = 1'b1;
		write_reg(ADDR_CTRL, word);
		wait_panel_reset(1'b0);
		read_reg(ADDR_CTRL);
		word.ctrl.panel_rst = 1'b0;
		write_reg(ADDR_CTRL, word);
		wait_panel_reset(1'b1);

		test_name = "unmapped address";
		falls = cs_falls;
		read_reg(ADDR_NONE);
		write_reg(ADDR_NONE, $random(seed));
		read_reg(ADDR_NONE);
		check_value("chip selects", 32'(falls), 32'(cs_falls));
		read_reg(ADDR_INDEX);
		read_reg(ADDR_DATA);

		test_name = "back-pressure";
		falls = cs_falls;
		host_access(1'b0, ADDR_DATA, 32'd0, 20);
		check_value("chip selects", 32'(falls + 1), 32'(cs_falls));

		repeat (2) @(posedge clock);
		if (reads_compared != reads_issued) begin
			$display("comparison saw %0d reads, %0d were issued", reads_compared, reads_issued);
			errors++;
		end
		$display("checks: %0d, reads compared: %0d, errors: %0d",
			checks, reads_compared, errors + cmp_errors);
		if (errors + cmp_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+logic
logic/lcd_host_pkg.sv
logic/lcd_panel_pkg.sv
logic/lcd_phase_timer.sv
logic/lcd_bus_fsm.sv
logic/lcd_data_path.sv
logic/lcd_i80_ctrl.sv
test/lcd_panel_model.sv
test/tb_lcd_i80_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only if the pass message shows up.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_lcd_i80_ctrl -f project.f \
	|| { echo "verilator build failed"; exit 1; }

sim_output="$(./obj_dir/Vtb_lcd_i80_ctrl)" || { echo "$sim_output"; exit 1; }
echo "$sim_output"

echo "$sim_output" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
